/* include/boom_config.svh */
`ifndef BOOM_CONFIG_SVH
`define BOOM_CONFIG_SVH

// visible screen in pixels
`define SCREEN_W 320
`define SCREEN_H 240

// one frame buffer word carries this many horizontally adjacent pixels
`define WORD_BITS 16

// SCREEN_W / WORD_BITS
`define WORDS_PER_ROW 20

// words in the bit map, WORDS_PER_ROW * SCREEN_H
`define FB_DEPTH 4800

// enough to address FB_DEPTH words
`define FB_ADDR_BITS 13

`endif

/* logic/boomPkg.sv */
`include "boom_config.svh"

package boomPkg;

  // screen coordinates
  typedef logic [$clog2(`SCREEN_W)-1:0] pixelX_t;
  typedef logic [$clog2(`SCREEN_H)-1:0] pixelY_t;

  // word address is row * WORDS_PER_ROW + word column
  typedef logic [`FB_ADDR_BITS-1:0] fbAddr_t;

  // bit i of a word is the pixel at x = WORD_BITS * column + i
  typedef logic [`WORD_BITS-1:0] fbWord_t;

  typedef enum logic [1:0] {
    PNT_IDLE,
    PNT_FEED,
    PNT_WRITE,
    PNT_DONE
  } painterState_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_BUS,
    RD_REPLY
  } readerState_t;

endpackage

/* logic/boomGlyph.sv */
`timescale 1ns/10ps

module boomGlyph import boomPkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  pixelX_t originX,
  input  pixelY_t originY,
  input  pixelX_t x,
  input  pixelY_t y,
  output logic    boomPixel
);

  // horizontal bars, offsets from the origin
  localparam pixelX_t horX [8] = '{
    9'd4, 9'd27, 9'd60, 9'd60, 9'd93, 9'd93, 9'd126, 9'd126
  };
  localparam pixelY_t horY [8] = '{
    8'd42, 8'd42, 8'd0, 8'd42, 8'd0, 8'd42, 8'd0, 8'd42
  };

  // vertical bars come in upper and lower pairs per column
  localparam pixelX_t verX [16] = '{
    9'd0, 9'd0, 9'd23, 9'd23, 9'd46, 9'd46, 9'd56, 9'd56,
    9'd79, 9'd79, 9'd89, 9'd89, 9'd112, 9'd112, 9'd122, 9'd122
  };
  localparam pixelY_t verY [16] = '{
    8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24,
    8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24
  };

  // one extra bit of headroom so the lettering clips at the screen edge
  logic [9:0] baseX;
  logic [9:0] baseY;
  logic [9:0] px;
  logic [9:0] py;
  logic       boomDetect;

  assign baseX = {1'b0, originX};
  assign baseY = {2'b00, originY};
  assign px = {1'b0, x};
  assign py = {2'b00, y};

  // a stroke is five pixels thick; its outer rows are cut short by 2,
  // the next ones in by 1, on whichever ends are tapered
  function automatic logic strokeHit(
    input logic [9:0] along,
    input logic [9:0] across,
    input logic [9:0] alongBase,
    input logic [9:0] acrossBase,
    input logic [4:0] len,
    input logic       taperLo,
    input logic       taperHi
  );
    logic [9:0] d;
    logic [1:0] cut;
    logic [9:0] lo;
    logic [9:0] hi;
    d = across - acrossBase;
    if (d == 10'd0 || d == 10'd4) begin
      cut = 2'd2;
    end else if (d == 10'd1 || d == 10'd3) begin
      cut = 2'd1;
    end else begin
      cut = 2'd0;
    end
    lo = alongBase + (taperLo ? cut : 2'd0);
    hi = alongBase + len - 10'd1 - (taperHi ? cut : 2'd0);
    strokeHit = (across >= acrossBase) && (across <= acrossBase + 10'd4) &&
                (along >= lo) && (along <= hi);
  endfunction

  always_comb begin
    boomDetect = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (strokeHit(px, py, baseX + horX[i], baseY + horY[i], 5'd20, 1'b1, 1'b1)) begin
        boomDetect = 1'b1;
      end
    end
    for (int j = 0; j < 16; j++) begin
      if (strokeHit(py, px, baseY + verY[j], baseX + verX[j], 5'd20, 1'b1, 1'b1)) begin
        boomDetect = 1'b1;
      end
    end
    // lower spine of the B, tapered only at its top
    if (strokeHit(py, px, baseY + 10'd24, baseX + 10'd137, 5'd17, 1'b1, 1'b0)) begin
      boomDetect = 1'b1;
    end
    // short middle bar of the B
    if (strokeHit(px, py, baseX + 10'd126, baseY + 10'd21, 5'd12, 1'b1, 1'b1)) begin
      boomDetect = 1'b1;
    end
    // upper spine of the B, tapered only at its bottom
    if (strokeHit(py, px, baseY + 10'd6, baseX + 10'd137, 5'd17, 1'b0, 1'b1)) begin
      boomDetect = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      boomPixel <= 1'b0;
    end else begin
      boomPixel <= boomDetect;
    end
  end

endmodule

/* logic/bannerPainter.sv */
`timescale 1ns/10ps
`include "boom_config.svh"

module bannerPainter import boomPkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  logic    start,
  input  pixelX_t originX,
  input  pixelY_t originY,
  output logic    busy,
  output logic    done,
  output pixelX_t glyphOriginX,
  output pixelY_t glyphOriginY,
  output pixelX_t glyphX,
  output pixelY_t glyphY,
  input  logic    glyphPixel,
  output logic    pntCyc,
  output logic    pntStb,
  output logic    pntWe,
  output fbAddr_t pntAdr,
  output fbWord_t pntDatW,
  input  logic    pntAck
);

  painterState_t state;
  // 0..15 feed the glyph, 16 is the drain cycle
  logic [4:0]    feedCnt;
  logic [4:0]    wordCol;
  pixelY_t       row;
  fbAddr_t       adr;
  fbWord_t       pixWord;
  logic          lastWord;

  assign lastWord = (row == `SCREEN_H - 1) && (wordCol == `WORDS_PER_ROW - 1);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state <= PNT_IDLE;
      feedCnt <= '0;
      wordCol <= '0;
      row <= '0;
      adr <= '0;
    end else begin
      case (state)
        PNT_IDLE: begin
          if (start) begin
            state <= PNT_FEED;
            feedCnt <= '0;
            wordCol <= '0;
            row <= '0;
            adr <= '0;
          end
        end
        PNT_FEED: begin
          if (feedCnt == 5'd16) begin
            state <= PNT_WRITE;
          end else begin
            feedCnt <= feedCnt + 5'd1;
          end
        end
        PNT_WRITE: begin
          if (pntAck) begin
            feedCnt <= '0;
            adr <= adr + 1'b1;
            if (lastWord) begin
              state <= PNT_DONE;
            end else begin
              state <= PNT_FEED;
              if (wordCol == `WORDS_PER_ROW - 1) begin
                wordCol <= '0;
                row <= row + 1'b1;
              end else begin
                wordCol <= wordCol + 5'd1;
              end
            end
          end
        end
        default: begin
          state <= PNT_IDLE;
        end
      endcase
    end
  end

  // origin is held for the whole paint
  always_ff @(posedge clk) begin
    if (state == PNT_IDLE && start) begin
      glyphOriginX <= originX;
      glyphOriginY <= originY;
    end
  end

  // glyph answers one cycle late, so feed cycles 1..16 collect pixels 0..15
  always_ff @(posedge clk) begin
    if (state == PNT_FEED && feedCnt != 5'd0) begin
      pixWord <= {glyphPixel, pixWord[`WORD_BITS-1:1]};
    end
  end

  assign glyphX = {wordCol, feedCnt[3:0]};
  assign glyphY = row;

  assign pntCyc = (state == PNT_WRITE);
  assign pntStb = (state == PNT_WRITE);
  // painter never reads
  assign pntWe = 1'b1;
  assign pntAdr = adr;
  assign pntDatW = pixWord;

  assign busy = (state != PNT_IDLE);
  assign done = (state == PNT_DONE);

endmodule

/* logic/pixelReader.sv */
`timescale 1ns/10ps
`include "boom_config.svh"

module pixelReader import boomPkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  logic    qReq,
  input  pixelX_t qX,
  input  pixelY_t qY,
  output logic    qReady,
  output logic    qValid,
  output logic    qPixel,
  output logic    rdCyc,
  output logic    rdStb,
  output fbAddr_t rdAdr,
  input  logic    rdAck,
  input  fbWord_t rdDatR
);

  readerState_t state;
  fbAddr_t      adr;
  // pixel position inside the word
  logic [3:0]   bitSel;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: begin
          if (qReq) begin
            state <= RD_BUS;
          end
        end
        RD_BUS: begin
          if (rdAck) begin
            state <= RD_REPLY;
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RD_IDLE && qReq) begin
      adr <= fbAddr_t'(qY * `WORDS_PER_ROW + qX[8:4]);
      bitSel <= qX[3:0];
    end
    if (state == RD_BUS && rdAck) begin
      qPixel <= rdDatR[bitSel];
    end
  end

  assign qReady = (state == RD_IDLE);
  assign qValid = (state == RD_REPLY);
  assign rdCyc = (state == RD_BUS);
  assign rdStb = (state == RD_BUS);
  assign rdAdr = adr;

endmodule

/* logic/busArbiter.sv */
`timescale 1ns/10ps

module busArbiter import boomPkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  logic    pntCyc,
  input  logic    pntStb,
  input  logic    pntWe,
  input  fbAddr_t pntAdr,
  input  fbWord_t pntDatW,
  output logic    pntAck,
  output fbWord_t pntDatR,
  input  logic    rdCyc,
  input  logic    rdStb,
  input  logic    rdWe,
  input  fbAddr_t rdAdr,
  input  fbWord_t rdDatW,
  output logic    rdAck,
  output fbWord_t rdDatR,
  output logic    fbCyc,
  output logic    fbStb,
  output logic    fbWe,
  output fbAddr_t fbAdr,
  output fbWord_t fbDatW,
  input  logic    fbAck,
  input  fbWord_t fbDatR
);

  logic ownPnt;
  logic ownRd;
  // set when the reader had the bus most recently
  logic lastRd;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      ownPnt <= 1'b0;
      ownRd <= 1'b0;
      lastRd <= 1'b0;
    end else if (ownPnt) begin
      if (!pntCyc) begin
        ownPnt <= 1'b0;
      end
    end else if (ownRd) begin
      if (!rdCyc) begin
        ownRd <= 1'b0;
      end
    end else if (pntCyc && (!rdCyc || lastRd)) begin
      ownPnt <= 1'b1;
      lastRd <= 1'b0;
    end else if (rdCyc) begin
      ownRd <= 1'b1;
      lastRd <= 1'b1;
    end
  end

  always_comb begin
    fbCyc = 1'b0;
    fbStb = 1'b0;
    fbWe = 1'b0;
    fbAdr = pntAdr;
    fbDatW = pntDatW;
    if (ownPnt) begin
      fbCyc = pntCyc;
      fbStb = pntStb;
      fbWe = pntWe;
    end else if (ownRd) begin
      fbCyc = rdCyc;
      fbStb = rdStb;
      fbWe = rdWe;
      fbAdr = rdAdr;
      fbDatW = rdDatW;
    end
  end

  // only the owner ever sees ack
  assign pntAck = ownPnt & fbAck;
  assign rdAck = ownRd & fbAck;
  assign pntDatR = fbDatR;
  assign rdDatR = fbDatR;

endmodule

/* logic/frameBuffer.sv */
`timescale 1ns/10ps
`include "boom_config.svh"

module frameBuffer import boomPkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  logic    fbCyc,
  input  logic    fbStb,
  input  logic    fbWe,
  input  fbAddr_t fbAdr,
  input  fbWord_t fbDatW,
  output logic    fbAck,
  output fbWord_t fbDatR
);

  fbWord_t mem [`FB_DEPTH];
  logic    access;

  // a new access starts only while no ack is out
  assign access = fbCyc && fbStb && !fbAck;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      fbAck <= 1'b0;
    end else begin
      fbAck <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access && fbWe) begin
      mem[fbAdr] <= fbDatW;
    end
    if (access && !fbWe) begin
      fbDatR <= mem[fbAdr];
    end
  end

endmodule

/* logic/boomDisplay.sv */
`timescale 1ns/10ps

module boomDisplay import boomPkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  logic    start,
  input  pixelX_t originX,
  input  pixelY_t originY,
  output logic    busy,
  output logic    done,
  input  logic    qReq,
  input  pixelX_t qX,
  input  pixelY_t qY,
  output logic    qReady,
  output logic    qValid,
  output logic    qPixel
);

  pixelX_t glyphOriginX;
  pixelY_t glyphOriginY;
  pixelX_t glyphX;
  pixelY_t glyphY;
  logic    glyphPixel;

  logic    pntCyc;
  logic    pntStb;
  logic    pntWe;
  fbAddr_t pntAdr;
  fbWord_t pntDatW;
  logic    pntAck;

  logic    rdCyc;
  logic    rdStb;
  fbAddr_t rdAdr;
  logic    rdAck;
  fbWord_t rdDatR;

  logic    fbCyc;
  logic    fbStb;
  logic    fbWe;
  fbAddr_t fbAdr;
  fbWord_t fbDatW;
  logic    fbAck;
  fbWord_t fbDatR;

  boomGlyph glyph0 (
    .clk(clk),
    .nrst(nrst),
    .originX(glyphOriginX),
    .originY(glyphOriginY),
    .x(glyphX),
    .y(glyphY),
    .boomPixel(glyphPixel)
  );

  bannerPainter painter0 (
    .clk(clk),
    .nrst(nrst),
    .start(start),
    .originX(originX),
    .originY(originY),
    .busy(busy),
    .done(done),
    .glyphOriginX(glyphOriginX),
    .glyphOriginY(glyphOriginY),
    .glyphX(glyphX),
    .glyphY(glyphY),
    .glyphPixel(glyphPixel),
    .pntCyc(pntCyc),
    .pntStb(pntStb),
    .pntWe(pntWe),
    .pntAdr(pntAdr),
    .pntDatW(pntDatW),
    .pntAck(pntAck)
  );

  pixelReader reader0 (
    .clk(clk),
    .nrst(nrst),
    .qReq(qReq),
    .qX(qX),
    .qY(qY),
    .qReady(qReady),
    .qValid(qValid),
    .qPixel(qPixel),
    .rdCyc(rdCyc),
    .rdStb(rdStb),
    .rdAdr(rdAdr),
    .rdAck(rdAck),
    .rdDatR(rdDatR)
  );

  // reader is read only and the painter takes no read data
  busArbiter arbiter0 (
    .clk(clk),
    .nrst(nrst),
    .pntCyc(pntCyc),
    .pntStb(pntStb),
    .pntWe(pntWe),
    .pntAdr(pntAdr),
    .pntDatW(pntDatW),
    .pntAck(pntAck),
    .pntDatR(),
    .rdCyc(rdCyc),
    .rdStb(rdStb),
    .rdWe(1'b0),
    .rdAdr(rdAdr),
    .rdDatW('0),
    .rdAck(rdAck),
    .rdDatR(rdDatR),
    .fbCyc(fbCyc),
    .fbStb(fbStb),
    .fbWe(fbWe),
    .fbAdr(fbAdr),
    .fbDatW(fbDatW),
    .fbAck(fbAck),
    .fbDatR(fbDatR)
  );

  frameBuffer fb0 (
    .clk(clk),
    .nrst(nrst),
    .fbCyc(fbCyc),
    .fbStb(fbStb),
    .fbWe(fbWe),
    .fbAdr(fbAdr),
    .fbDatW(fbDatW),
    .fbAck(fbAck),
    .fbDatR(fbDatR)
  );

endmodule

/* test/boomDisplay_tb.sv */
`timescale 1ns/10ps
`include "boom_config.svh"

module boomDisplay_tb import boomPkg::*; ();

  // three paints of about 100k cycles each plus all queries, with margin
  localparam int TIMEOUT_CYCLES = 400000;
  localparam int RANDOM_QUERIES = 400;

  logic    clk;
  logic    nrst;
  logic    start;
  pixelX_t originX;
  pixelY_t originY;
  logic    busy;
  logic    done;
  logic    qReq;
  pixelX_t qX;
  pixelY_t qY;
  logic    qReady;
  logic    qValid;
  logic    qPixel;

  int cycleCount;
  // expected pixel of every query still waiting for qValid
  bit expectQ [$];

  // lettering offsets from the origin
  int horX [8] = '{4, 27, 60, 60, 93, 93, 126, 126};
  int horY [8] = '{42, 42, 0, 42, 0, 42, 0, 42};
  // each column holds an upper bar at +3 and a lower bar at +24
  int colX [8] = '{0, 23, 46, 56, 79, 89, 112, 122};

  boomDisplay dut0 (
    .clk(clk),
    .nrst(nrst),
    .start(start),
    .originX(originX),
    .originY(originY),
    .busy(busy),
    .done(done),
    .qReq(qReq),
    .qX(qX),
    .qY(qY),
    .qReady(qReady),
    .qValid(qValid),
    .qPixel(qPixel)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic abortRun(string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      abortRun($sformatf("mismatch at time %0t: %s expected %0h, got %0h",
                         $time, name, expected, actual));
    end
  endtask

  // five pixels thick; outer rows lose 2 pixels per tapered end, next rows lose 1
  function automatic bit inStroke(int along, int across, int alongBase, int acrossBase,
                                  int len, bit taperLo, bit taperHi);
    int d;
    int cut;
    d = across - acrossBase;
    if (d < 0 || d > 4) begin
      return 1'b0;
    end
    cut = (d == 2) ? 0 : ((d == 1 || d == 3) ? 1 : 2);
    return (along >= alongBase + (taperLo ? cut : 0)) &&
           (along <= alongBase + len - 1 - (taperHi ? cut : 0));
  endfunction

  function automatic bit refPixel(int ox, int oy, int x, int y);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < 8; i++) begin
      hit |= inStroke(x, y, ox + horX[i], oy + horY[i], 20, 1'b1, 1'b1);
    end
    for (int c = 0; c < 8; c++) begin
      hit |= inStroke(y, x, oy + 3, ox + colX[c], 20, 1'b1, 1'b1);
      hit |= inStroke(y, x, oy + 24, ox + colX[c], 20, 1'b1, 1'b1);
    end
    // two spine halves of the B and its short middle bar
    hit |= inStroke(y, x, oy + 24, ox + 137, 17, 1'b1, 1'b0);
    hit |= inStroke(x, y, ox + 126, oy + 21, 12, 1'b1, 1'b1);
    hit |= inStroke(y, x, oy + 6, ox + 137, 17, 1'b0, 1'b1);
    return hit;
  endfunction

  // the lettering box is 146 x 47 pixels
  task automatic randomPixel(int ox, int oy, bit inBox, output pixelX_t x, output pixelY_t y);
    if (inBox) begin
      x = pixelX_t'(ox + $urandom % 146);
      y = pixelY_t'(oy + $urandom % 47);
    end else begin
      x = pixelX_t'($urandom % `SCREEN_W);
      y = pixelY_t'($urandom % `SCREEN_H);
    end
  endtask

  task automatic issueQuery(pixelX_t x, pixelY_t y, bit expected);
    @(negedge clk);
    while (qReady !== 1'b1) begin
      @(negedge clk);
    end
    qReq = 1'b1;
    qX = x;
    qY = y;
    expectQ.push_back(expected);
    @(negedge clk);
    qReq = 1'b0;
    checkValue("qReady", 1'b0, qReady);
  endtask

  task automatic waitReplies();
    while (expectQ.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic sweepWindow(int ox, int oy, int x0, int y0, int w, int h);
    for (int dy = 0; dy < h; dy++) begin
      for (int dx = 0; dx < w; dx++) begin
        issueQuery(pixelX_t'(x0 + dx), pixelY_t'(y0 + dy), refPixel(ox, oy, x0 + dx, y0 + dy));
      end
    end
  endtask

  task automatic startPaint(pixelX_t ox, pixelY_t oy);
    @(negedge clk);
    start = 1'b1;
    originX = ox;
    originY = oy;
    @(negedge clk);
    start = 1'b0;
    checkValue("busy", 1'b1, busy);
  endtask

  // busy stays high up to the single done pulse; optionally pokes start midway
  task automatic watchPaint(bit pulseAgain);
    int cycles;
    cycles = 0;
    while (done !== 1'b1) begin
      checkValue("busy", 1'b1, busy);
      @(negedge clk);
      cycles++;
      if (pulseAgain && cycles == 3000) begin
        start = 1'b1;
        originX = 9'd10;
        originY = 8'd150;
      end else begin
        start = 1'b0;
      end
    end
    checkValue("busy", 1'b1, busy);
    @(negedge clk);
    checkValue("done", 1'b0, done);
    checkValue("busy", 1'b0, busy);
  endtask

  // replies come back in query order, one per query
  always @(negedge clk) begin
    if (nrst === 1'b1 && qValid === 1'b1) begin
      if (expectQ.size() == 0) begin
        abortRun("qValid came without an outstanding pixel query");
      end else begin
        checkValue("qPixel", expectQ.pop_front(), qPixel);
      end
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycleCount++;
    end
    abortRun($sformatf("timeout: the run hung and was stopped after %0d cycles", cycleCount));
  end

  initial begin
    pixelX_t x;
    pixelY_t y;
    int cleared;
    void'($urandom(32'h3a7d_470a));
    nrst = 1'b0;
    start = 1'b0;
    originX = '0;
    originY = '0;
    qReq = 1'b0;
    qX = '0;
    qY = '0;
    repeat (10) @(negedge clk);
    nrst = 1'b1;
    checkValue("busy", 1'b0, busy);
    checkValue("done", 1'b0, done);
    checkValue("qValid", 1'b0, qValid);
    checkValue("qReady", 1'b1, qReady);

    startPaint(9'd82, 8'd96);
    watchPaint(1'b0);
    for (int n = 0; n < RANDOM_QUERIES; n++) begin
      randomPixel(82, 96, (n % 2) == 0, x, y);
      issueQuery(x, y, refPixel(82, 96, x, y));
    end
    // horizontal bar spans x 86..105 across the 95/96 word boundary
    sweepWindow(82, 96, 85, 137, 22, 7);
    // vertical bar starts at x 128, just past the 127/128 boundary
    sweepWindow(82, 96, 127, 98, 7, 22);
    waitReplies();

    // repaint with the reader competing for the bus the whole time
    startPaint(9'd82, 8'd96);
    fork
      watchPaint(1'b1);
      while (busy === 1'b1) begin
        randomPixel(82, 96, 1'b1, x, y);
        issueQuery(x, y, refPixel(82, 96, x, y));
      end
    join
    for (int n = 0; n < 100; n++) begin
      randomPixel(82, 96, 1'b1, x, y);
      issueQuery(x, y, refPixel(82, 96, x, y));
    end
    waitReplies();

    startPaint(9'd10, 8'd150);
    watchPaint(1'b0);
    for (int n = 0; n < 200; n++) begin
      randomPixel(10, 150, (n % 2) == 0, x, y);
      issueQuery(x, y, refPixel(10, 150, x, y));
    end
    // old lettering must be wiped wherever the new one is clear
    cleared = 0;
    while (cleared < 60) begin
      randomPixel(82, 96, 1'b1, x, y);
      if (refPixel(82, 96, x, y) && !refPixel(10, 150, x, y)) begin
        issueQuery(x, y, 1'b0);
        cleared++;
      end
    end
    waitReplies();
    $display("All tests passed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
logic/boomPkg.sv
logic/boomGlyph.sv
logic/bannerPainter.sv
logic/pixelReader.sv
logic/busArbiter.sv
logic/frameBuffer.sv
logic/boomDisplay.sv
test/boomDisplay_tb.sv

/* Bender.yml */
package:
  name: boom_display

export_include_dirs:
  - include

sources:
  - logic/boomPkg.sv
  - logic/boomGlyph.sv
  - logic/bannerPainter.sv
  - logic/pixelReader.sv
  - logic/busArbiter.sv
  - logic/frameBuffer.sv
  - logic/boomDisplay.sv
  - target: test
    files:
      - test/boomDisplay_tb.sv
